/* verilog/fp16_alu_pkg.sv */
// ========================================
// FP16/BF16 ALU shared definitions
// Format constants, special encodings and field types
// ========================================

`default_nettype none

package fp16_alu_pkg;

    // ========================================
    // Field types
    // ========================================

    // Raw 16-bit word in either format
    typedef logic [15:0] fp_word_t;

    // Exponent widened to 8 bits for both formats
    typedef logic [7:0] exp_t;

    // Implicit bit plus 10 fraction bits, BF16 left aligned
    typedef logic [10:0] man_t;

    // ========================================
    // Format constants
    // ========================================
    localparam exp_t FP16_BIAS    = 8'd15;
    localparam exp_t BF16_BIAS    = 8'd127;

    // All-ones exponent marks Inf or NaN
    localparam exp_t FP16_EXP_MAX = 8'd31;
    localparam exp_t BF16_EXP_MAX = 8'd255;

    // Canonical quiet NaNs
    localparam fp_word_t FP16_QNAN = 16'h7E00;
    localparam fp_word_t BF16_QNAN = 16'h7FC0;

    // Positive infinities, set bit 15 for the negative one
    localparam fp_word_t FP16_PINF = 16'h7C00;
    localparam fp_word_t BF16_PINF = 16'h7F80;

endpackage

`default_nettype wire

/* verilog/fp_operand_if.sv */
// ========================================
// Decoded operand bundle
// Carries one unpacked operand to the execute units
// ========================================

`timescale 1ns/1ns
`default_nettype none

interface fp_operand_if;
    import fp16_alu_pkg::*;

    logic     sign;
    // Widened exponent and significand
    exp_t     exp;
    man_t     man;
    // Classification flags
    logic     is_nan;
    logic     is_inf;
    logic     is_zero;
    // Original word, used for magnitude compare and pass-through
    fp_word_t raw;

    // Decoder side
    modport source (output sign, exp, man, is_nan, is_inf, is_zero, raw);

    // Execute side
    modport sink (input sign, exp, man, is_nan, is_inf, is_zero, raw);

endinterface

`default_nettype wire

/* verilog/fp_operand_decode.sv */
// ========================================
// Operand decoder
// Unpacks and classifies one FP16 or BF16 word
// ========================================

`timescale 1ns/1ns
`default_nettype none

module fp_operand_decode (
    input  logic                   is_bf16,
    input  fp16_alu_pkg::fp_word_t word,
    fp_operand_if.source           op
);
    import fp16_alu_pkg::*;

    exp_t exp_w;
    exp_t exp_max;
    // Fraction bits padded to 10 bits
    logic [9:0] frac_w;
    logic       frac_nz;
    logic       exp_nz;

    // Field positions by format
    // FP16 is 1/5/10, BF16 is 1/8/7
    always_comb begin
        if (is_bf16) begin
            exp_w   = word[14:7];
            frac_w  = {word[6:0], 3'b000};
            exp_max = BF16_EXP_MAX;
        end else begin
            exp_w   = {3'b000, word[14:10]};
            frac_w  = word[9:0];
            exp_max = FP16_EXP_MAX;
        end
    end

    assign frac_nz = |frac_w;
    assign exp_nz  = |exp_w;

    assign op.sign = word[15];
    assign op.exp  = exp_w;
    // Implicit one only for normal numbers
    assign op.man  = {exp_nz, frac_w};
    assign op.raw  = word;

    // Classification
    assign op.is_nan  = (exp_w == exp_max) && frac_nz;
    assign op.is_inf  = (exp_w == exp_max) && !frac_nz;
    assign op.is_zero = !exp_nz && !frac_nz;

endmodule

`default_nettype wire

/* verilog/fp_mul_execute.sv */
// ========================================
// FP16/BF16 multiplier
// Significand product, RNE rounding and packing
// Subnormal results flush to signed zero
// ========================================

`timescale 1ns/1ns
`default_nettype none

module fp_mul_execute (
    input  logic                    is_bf16,
    fp_operand_if.sink              opa,
    fp_operand_if.sink              opb,
    output fp16_alu_pkg::fp_word_t  mul_result
);
    import fp16_alu_pkg::*;

    exp_t        bias;
    exp_t        exp_max;
    fp_word_t    qnan;
    fp_word_t    pinf;
    logic        prod_sign;
    logic [21:0] prod;
    logic [21:0] norm;
    logic        norm_up;
    logic        below_one;
    logic        sticky16;
    logic        sticky_bf;
    logic        round16;
    logic        round_bf;
    logic [11:0] sig16;
    logic [8:0]  sig_bf;
    logic        carry;
    logic [10:0] exp_res;

    assign bias      = is_bf16 ? BF16_BIAS : FP16_BIAS;
    assign exp_max   = is_bf16 ? BF16_EXP_MAX : FP16_EXP_MAX;
    assign qnan      = is_bf16 ? BF16_QNAN : FP16_QNAN;
    assign pinf      = is_bf16 ? BF16_PINF : FP16_PINF;
    assign prod_sign = opa.sign ^ opb.sign;

    // ========================================
    // Product and normalisation
    // ========================================

    // 1.10 x 1.10 gives 2.20, bit 20 weighs 1.0
    assign prod      = {11'd0, opa.man} * {11'd0, opb.man};
    assign norm_up   = prod[21];
    assign below_one = !prod[21] && !prod[20];
    // Product at least two, shift right by one
    assign norm      = norm_up ? {1'b0, prod[21:1]} : prod;

    // ========================================
    // Round to nearest even
    // ========================================

    // FP16 keeps norm[19:10], guard at bit 9
    // Bit shifted out by normalisation joins sticky
    assign sticky16 = (|norm[8:0]) | (norm_up & prod[0]);
    assign round16  = norm[9] & (sticky16 | norm[10]);
    assign sig16    = {1'b0, norm[20:10]} + {11'd0, round16};

    // BF16 keeps norm[19:13], guard at bit 12
    assign sticky_bf = (|norm[11:0]) | (norm_up & prod[0]);
    assign round_bf  = norm[12] & (sticky_bf | norm[13]);
    assign sig_bf    = {1'b0, norm[20:13]} + {8'd0, round_bf};

    // Rounding carry leaves the fraction bits all zero
    assign carry = is_bf16 ? sig_bf[8] : sig16[11];

    // Biased exponent, bit 10 set means negative
    assign exp_res = {3'b000, opa.exp} + {3'b000, opb.exp} - {3'b000, bias}
                   + {10'd0, norm_up} + {10'd0, carry};

    // ========================================
    // Special cases and packing
    // ========================================
    always_comb begin
        if (opa.is_nan || opb.is_nan ||
            (opa.is_inf && opb.is_zero) || (opb.is_inf && opa.is_zero)) begin
            mul_result = qnan;
        end else if (opa.is_inf || opb.is_inf) begin
            mul_result = {prod_sign, pinf[14:0]};
        end else if (opa.is_zero || opb.is_zero || below_one ||
                     exp_res[10] || (exp_res == 11'd0)) begin
            // Zero operand or underflow
            mul_result = {prod_sign, 15'd0};
        end else if (exp_res >= {3'b000, exp_max}) begin
            // Overflow to signed infinity
            mul_result = {prod_sign, pinf[14:0]};
        end else if (is_bf16) begin
            mul_result = {prod_sign, exp_res[7:0], sig_bf[6:0]};
        end else begin
            mul_result = {prod_sign, exp_res[4:0], sig16[9:0]};
        end
    end

endmodule

`default_nettype wire

/* verilog/fp_compare_execute.sv */
// ========================================
// Compare, min/max and abs unit
// Ordered compare with NaN propagation
// ========================================

`timescale 1ns/1ns
`default_nettype none

module fp_compare_execute (
    fp_operand_if.sink              opa,
    fp_operand_if.sink              opb,
    input  logic                    is_bf16,
    output fp16_alu_pkg::fp_word_t  min_result,
    output fp16_alu_pkg::fp_word_t  max_result,
    output fp16_alu_pkg::fp_word_t  abs_result,
    output logic                    a_lt_b,
    output logic                    a_gt_b
);
    import fp16_alu_pkg::*;

    fp_word_t    qnan;
    logic        any_nan;
    logic [14:0] mag_a;
    logic [14:0] mag_b;

    assign qnan    = is_bf16 ? BF16_QNAN : FP16_QNAN;
    assign any_nan = opa.is_nan || opb.is_nan;
    // Sign-magnitude ordering works for both formats
    assign mag_a   = opa.raw[14:0];
    assign mag_b   = opb.raw[14:0];

    // Ordered compare
    always_comb begin
        if (any_nan || (opa.is_zero && opb.is_zero)) begin
            // Unordered, or +0 equal to -0
            a_lt_b = 1'b0;
            a_gt_b = 1'b0;
        end else if (opa.sign != opb.sign) begin
            // Negative side is smaller
            a_lt_b = opa.sign;
            a_gt_b = opb.sign;
        end else if (opa.sign) begin
            // Both negative, order reversed
            a_lt_b = mag_a > mag_b;
            a_gt_b = mag_a < mag_b;
        end else begin
            a_lt_b = mag_a < mag_b;
            a_gt_b = mag_a > mag_b;
        end
    end

    // NaN on either side propagates
    assign min_result = any_nan ? qnan : (a_lt_b ? opa.raw : opb.raw);
    assign max_result = any_nan ? qnan : (a_gt_b ? opa.raw : opb.raw);
    assign abs_result = {1'b0, mag_a};

endmodule

`default_nettype wire

/* verilog/fp_result_stage.sv */
// ========================================
// Result select and output register
// One cycle from operands to outputs
// ========================================

`timescale 1ns/1ns
`default_nettype none

module fp_result_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    op_mul,
    input  logic                    op_min,
    input  logic                    op_max,
    input  logic                    op_abs,
    input  logic                    op_cmp_lt,
    input  logic                    op_cmp_gt,
    input  fp16_alu_pkg::fp_word_t  mul_result,
    input  fp16_alu_pkg::fp_word_t  min_result,
    input  fp16_alu_pkg::fp_word_t  max_result,
    input  fp16_alu_pkg::fp_word_t  abs_result,
    input  logic                    a_lt_b,
    input  logic                    a_gt_b,
    input  logic                    nan_a,
    input  logic                    nan_b,
    output fp16_alu_pkg::fp_word_t  result,
    output logic                    cmp_out,
    output logic                    is_nan_a,
    output logic                    is_nan_b
);
    import fp16_alu_pkg::*;

    fp_word_t result_d;
    logic     cmp_d;

    // Priority mul, min, max, abs, else zero
    always_comb begin
        if (op_mul) begin
            result_d = mul_result;
        end else if (op_min) begin
            result_d = min_result;
        end else if (op_max) begin
            result_d = max_result;
        end else if (op_abs) begin
            result_d = abs_result;
        end else begin
            result_d = '0;
        end
    end

    // Less-than wins over greater-than
    assign cmp_d = op_cmp_lt ? a_lt_b : (op_cmp_gt ? a_gt_b : 1'b0);

    // Output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result   <= '0;
            cmp_out  <= 1'b0;
            is_nan_a <= 1'b0;
            is_nan_b <= 1'b0;
        end else begin
            result   <= result_d;
            cmp_out  <= cmp_d;
            // NaN flags follow the operands regardless of selects
            is_nan_a <= nan_a;
            is_nan_b <= nan_b;
        end
    end

endmodule

`default_nettype wire

/* verilog/fp16_alu.sv */
// ========================================
// Registered FP16/BF16 ALU
// Decode, multiply, compare and output stage
// ========================================

`timescale 1ns/1ns
`default_nettype none

module fp16_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    // Format select, high for BF16
    input  logic                    is_bf16,
    input  fp16_alu_pkg::fp_word_t  a,
    input  fp16_alu_pkg::fp_word_t  b,
    // One-hot operation selects
    input  logic                    op_mul,
    input  logic                    op_min,
    input  logic                    op_max,
    input  logic                    op_abs,
    input  logic                    op_cmp_lt,
    input  logic                    op_cmp_gt,
    output fp16_alu_pkg::fp_word_t  result,
    output logic                    is_nan_a,
    output logic                    is_nan_b,
    output logic                    cmp_out
);
    import fp16_alu_pkg::*;

    fp_word_t mul_result;
    fp_word_t min_result;
    fp_word_t max_result;
    fp_word_t abs_result;
    logic     a_lt_b;
    logic     a_gt_b;

    // ========================================
    // Operand decode
    // ========================================
    fp_operand_if opa ();
    fp_operand_if opb ();

    fp_operand_decode u_dec_a (.is_bf16(is_bf16), .word(a), .op(opa));
    fp_operand_decode u_dec_b (.is_bf16(is_bf16), .word(b), .op(opb));

    // ========================================
    // Execute units
    // ========================================
    fp_mul_execute u_mul (
        .is_bf16    (is_bf16),
        .opa        (opa),
        .opb        (opb),
        .mul_result (mul_result)
    );

    fp_compare_execute u_cmp (
        .opa        (opa),
        .opb        (opb),
        .is_bf16    (is_bf16),
        .min_result (min_result),
        .max_result (max_result),
        .abs_result (abs_result),
        .a_lt_b     (a_lt_b),
        .a_gt_b     (a_gt_b)
    );

    // Select and register
    fp_result_stage u_res (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_mul     (op_mul),
        .op_min     (op_min),
        .op_max     (op_max),
        .op_abs     (op_abs),
        .op_cmp_lt  (op_cmp_lt),
        .op_cmp_gt  (op_cmp_gt),
        .mul_result (mul_result),
        .min_result (min_result),
        .max_result (max_result),
        .abs_result (abs_result),
        .a_lt_b     (a_lt_b),
        .a_gt_b     (a_gt_b),
        .nan_a      (opa.is_nan),
        .nan_b      (opb.is_nan),
        .result     (result),
        .cmp_out    (cmp_out),
        .is_nan_a   (is_nan_a),
        .is_nan_b   (is_nan_b)
    );

endmodule

`default_nettype wire

/* sim/fp16_alu_checker.sv */
// ========================================
// FP16/BF16 ALU assertion checker
// Bound to the top level, checks reset, NaN and abs
// ========================================

`timescale 1ns/1ns
`default_nettype none

module fp16_alu_checker (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    is_bf16,
    input fp16_alu_pkg::fp_word_t  a,
    input fp16_alu_pkg::fp_word_t  b,
    input logic                    op_mul,
    input logic                    op_min,
    input logic                    op_max,
    input logic                    op_abs,
    input fp16_alu_pkg::fp_word_t  result,
    input logic                    cmp_out,
    input logic                    is_nan_a,
    input logic                    is_nan_b
);
    logic nan_in;
    logic abs_only;

    // NaN on either operand in the selected format
    assign nan_in = is_bf16 ? ((&a[14:7] && |a[6:0]) || (&b[14:7] && |b[6:0]))
                            : ((&a[14:10] && |a[9:0]) || (&b[14:10] && |b[9:0]));
    assign abs_only = op_abs && !op_mul && !op_min && !op_max;

    // Outputs cleared one cycle after a reset edge
    reset_clears: assert property (@(posedge clk)
        !rst_n |=> (result == 16'h0000) && !cmp_out && !is_nan_a && !is_nan_b)
        else $error("outputs not cleared after a reset edge");

    // NaN operands are unordered
    nan_unordered: assert property (@(posedge clk) disable iff (!rst_n)
        nan_in |=> !cmp_out)
        else $error("cmp_out high after a NaN operand");

    abs_sign_clear: assert property (@(posedge clk) disable iff (!rst_n)
        abs_only |=> !result[15])
        else $error("sign bit set after abs");

endmodule

bind fp16_alu fp16_alu_checker u_checker (
    .clk(clk), .rst_n(rst_n), .is_bf16(is_bf16), .a(a), .b(b),
    .op_mul(op_mul), .op_min(op_min), .op_max(op_max), .op_abs(op_abs),
    .result(result), .cmp_out(cmp_out), .is_nan_a(is_nan_a), .is_nan_b(is_nan_b)
);

`default_nettype wire

/* sim/fp16_alu_tb.sv */
// ========================================
// FP16/BF16 ALU testbench
// Directed tests of multiply, compare, min/max and abs
// ========================================

`timescale 1ns/1ns
`default_nettype none

module fp16_alu_tb;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_PAIRS  = 64;
    // Reset, then two cycles per operation in each test
    localparam int TEST_CYCLES = 6 + 2 * 16 + 2 * (4 * NUM_PAIRS + 6)
                               + 2 * (6 * NUM_PAIRS + 2) + 6;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;

    // Select bits {mul, min, max, abs, lt, gt}
    localparam logic [5:0] SEL_MUL = 6'b100000;
    localparam logic [5:0] SEL_MIN = 6'b010000;
    localparam logic [5:0] SEL_MAX = 6'b001000;
    localparam logic [5:0] SEL_ABS = 6'b000100;
    localparam logic [5:0] SEL_LT  = 6'b000010;
    localparam logic [5:0] SEL_GT  = 6'b000001;

    logic        clk;
    logic        rst_n;
    logic        is_bf16;
    logic [15:0] a;
    logic [15:0] b;
    logic        op_mul;
    logic        op_min;
    logic        op_max;
    logic        op_abs;
    logic        op_cmp_lt;
    logic        op_cmp_gt;
    logic [15:0] result;
    logic        is_nan_a;
    logic        is_nan_b;
    logic        cmp_out;

    int          error_count;
    int          check_count;
    int          test_count;
    int          failed_tests;
    logic [31:0] rng_state;
    // FP16 pairs first, then BF16 pairs
    logic [15:0] pair_a [0:2*NUM_PAIRS-1];
    logic [15:0] pair_b [0:2*NUM_PAIRS-1];

    fp16_alu uut (
        .clk(clk), .rst_n(rst_n), .is_bf16(is_bf16), .a(a), .b(b),
        .op_mul(op_mul), .op_min(op_min), .op_max(op_max), .op_abs(op_abs),
        .op_cmp_lt(op_cmp_lt), .op_cmp_gt(op_cmp_gt), .result(result),
        .is_nan_a(is_nan_a), .is_nan_b(is_nan_b), .cmp_out(cmp_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // Reference rules
    // ========================================
    function automatic logic [31:0] xorshift_next(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Finite, nonzero, non-NaN word from random bits
    function automatic logic [15:0] finite_operand(input logic [31:0] r, input logic bf);
        logic [4:0]  e5;
        logic [7:0]  e8;
        logic [15:0] w;
        e5 = r[14:10] % 5'd30 + 5'd1;
        e8 = r[14:7] % 8'd254 + 8'd1;
        w  = bf ? {r[15], e8, r[22:16]} : {r[15], e5, r[25:16]};
        return w;
    endfunction

    function automatic logic word_is_nan(input logic [15:0] w, input logic bf);
        logic nan;
        if (bf) begin
            nan = (w[14:7] == 8'hFF) && (w[6:0] != 7'd0);
        end else begin
            nan = (w[14:10] == 5'h1F) && (w[9:0] != 10'd0);
        end
        return nan;
    endfunction

    // Ordered less-than by sign and magnitude
    function automatic logic ordered_less(input logic [15:0] x, input logic [15:0] y,
                                          input logic bf);
        logic lt;
        if (word_is_nan(x, bf) || word_is_nan(y, bf)) begin
            lt = 1'b0;
        end else if ((x[14:0] == 15'd0) && (y[14:0] == 15'd0)) begin
            lt = 1'b0;
        end else if (x[15] != y[15]) begin
            lt = x[15];
        end else if (x[15]) begin
            lt = x[14:0] > y[14:0];
        end else begin
            lt = x[14:0] < y[14:0];
        end
        return lt;
    endfunction

    function automatic logic [15:0] quiet_nan(input logic bf);
        return bf ? 16'h7FC0 : 16'h7E00;
    endfunction

    function automatic logic [15:0] widen_bit(input logic v);
        return {15'd0, v};
    endfunction

    // ========================================
    // Drive and check
    // ========================================
    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        test_count++;
        if (error_count == errs_at_start) begin
            $display("test %-14s ok", name);
        end else begin
            failed_tests++;
            $display("test %-14s %0d mismatches", name, error_count - errs_at_start);
        end
    endtask

    task automatic drive_op(input logic bf, input logic [15:0] x, input logic [15:0] y,
                            input logic [5:0] sel);
        @(posedge clk);
        is_bf16 <= bf;
        a       <= x;
        b       <= y;
        {op_mul, op_min, op_max, op_abs, op_cmp_lt, op_cmp_gt} <= sel;
    endtask

    // Outputs sampled mid-cycle after the capturing edge
    task automatic run_op(input logic bf, input logic [15:0] x, input logic [15:0] y,
                          input logic [5:0] sel);
        drive_op(bf, x, y, sel);
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_result(input logic bf, input logic [15:0] x, input logic [15:0] y,
                                input logic [5:0] sel, input logic [15:0] expected);
        run_op(bf, x, y, sel);
        check_value("result", expected, result);
        check_value("is_nan_a", widen_bit(word_is_nan(x, bf)), widen_bit(is_nan_a));
        check_value("is_nan_b", widen_bit(word_is_nan(y, bf)), widen_bit(is_nan_b));
    endtask

    task automatic check_cmp(input logic bf, input logic [15:0] x, input logic [15:0] y,
                             input logic [5:0] sel, input logic expected);
        run_op(bf, x, y, sel);
        check_value("cmp_out", widen_bit(expected), widen_bit(cmp_out));
    endtask

    // All four outputs at their reset values
    task automatic check_cleared();
        check_value("result", 16'h0000, result);
        check_value("cmp_out", 16'h0000, widen_bit(cmp_out));
        check_value("is_nan_a", 16'h0000, widen_bit(is_nan_a));
        check_value("is_nan_b", 16'h0000, widen_bit(is_nan_b));
    endtask

    task automatic build_pairs();
        for (int i = 0; i < 2 * NUM_PAIRS; i++) begin
            rng_state = xorshift_next(rng_state);
            pair_a[i] = finite_operand(rng_state, i >= NUM_PAIRS);
            rng_state = xorshift_next(rng_state);
            pair_b[i] = finite_operand(rng_state, i >= NUM_PAIRS);
            // Some pairs equal, some equal magnitude with opposite signs
            if (i % 8 == 7) begin
                pair_b[i] = pair_a[i];
            end else if (i % 8 == 3) begin
                pair_b[i] = {~pair_a[i][15], pair_a[i][14:0]};
            end
        end
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic reset_test();
        int errs_at_start;
        errs_at_start = error_count;
        // Two NaN operands under abs first, so result or flag leaks show
        repeat (2) begin
            @(negedge clk);
            check_cleared();
        end
        // Then an ordered pair under less-than, so a cmp_out leak shows
        drive_op(1'b0, 16'hBC00, 16'h3C00, SEL_LT);
        repeat (2) begin
            @(negedge clk);
            check_cleared();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_cleared();
        end_test("reset", errs_at_start);
    endtask

    task automatic mul_test();
        int errs_at_start;
        errs_at_start = error_count;
        // 2 x 3 = 6, then 1.5 x 1.5 = 2.25
        check_result(1'b0, 16'h4000, 16'h4200, SEL_MUL, 16'h4600);
        check_result(1'b0, 16'h3E00, 16'h3E00, SEL_MUL, 16'h4080);
        // Tie at the guard bit rounds to the even fraction
        check_result(1'b0, 16'h3C01, 16'h3E00, SEL_MUL, 16'h3E02);
        check_result(1'b1, 16'h4000, 16'h4040, SEL_MUL, 16'h40C0);
        check_result(1'b0, 16'h7D00, 16'h4000, SEL_MUL, 16'h7E00);
        check_result(1'b1, 16'h4000, 16'hFF81, SEL_MUL, 16'h7FC0);
        // Inf x 0, Inf x -2, -0 x 5
        check_result(1'b0, 16'h7C00, 16'h0000, SEL_MUL, 16'h7E00);
        check_result(1'b1, 16'h0000, 16'hFF80, SEL_MUL, 16'h7FC0);
        check_result(1'b0, 16'h7C00, 16'hC000, SEL_MUL, 16'hFC00);
        check_result(1'b0, 16'h8000, 16'h4500, SEL_MUL, 16'h8000);
        // Overflow to infinity, underflow to signed zero
        check_result(1'b0, 16'h7BFF, 16'h7BFF, SEL_MUL, 16'h7C00);
        check_result(1'b1, 16'hFF7F, 16'h7F7F, SEL_MUL, 16'hFF80);
        check_result(1'b0, 16'h0400, 16'h8400, SEL_MUL, 16'h8000);
        check_result(1'b1, 16'h0080, 16'h0080, SEL_MUL, 16'h0000);
        end_test("multiply", errs_at_start);
    endtask

    task automatic compare_test();
        int   errs_at_start;
        logic bf;
        errs_at_start = error_count;
        for (int i = 0; i < 2 * NUM_PAIRS; i++) begin
            bf = (i >= NUM_PAIRS);
            check_cmp(bf, pair_a[i], pair_b[i], SEL_LT, ordered_less(pair_a[i], pair_b[i], bf));
            check_cmp(bf, pair_a[i], pair_b[i], SEL_GT, ordered_less(pair_b[i], pair_a[i], bf));
        end
        // Signed zeros are equal, NaN is unordered
        check_cmp(1'b0, 16'h8000, 16'h0000, SEL_LT, 1'b0);
        check_cmp(1'b0, 16'h0000, 16'h8000, SEL_GT, 1'b0);
        check_cmp(1'b1, 16'h8000, 16'h0000, SEL_LT, 1'b0);
        check_cmp(1'b0, 16'hFE00, 16'h3C00, SEL_LT, 1'b0);
        check_cmp(1'b0, 16'h3C00, 16'hFC01, SEL_GT, 1'b0);
        check_cmp(1'b1, 16'h3F80, 16'h7FC1, SEL_LT, 1'b0);
        end_test("compare", errs_at_start);
    endtask

    task automatic minmax_abs_test();
        int          errs_at_start;
        logic        bf;
        logic [15:0] x;
        logic [15:0] y;
        errs_at_start = error_count;
        for (int i = 0; i < 2 * NUM_PAIRS; i++) begin
            bf = (i >= NUM_PAIRS);
            x  = pair_a[i];
            y  = pair_b[i];
            check_result(bf, x, y, SEL_MIN, ordered_less(x, y, bf) ? x : y);
            check_result(bf, x, y, SEL_MAX, ordered_less(y, x, bf) ? x : y);
            check_result(bf, x, y, SEL_ABS, {1'b0, x[14:0]});
        end
        check_result(1'b0, 16'h7C01, 16'h3C00, SEL_MIN, quiet_nan(1'b0));
        check_result(1'b1, 16'h3F80, 16'hFFC0, SEL_MAX, quiet_nan(1'b1));
        end_test("min_max_abs", errs_at_start);
    endtask

    task automatic back_to_back_test();
        int          errs_at_start;
        logic [15:0] op_a [0:3];
        logic [15:0] op_b [0:3];
        logic [5:0]  op_sel [0:3];
        logic [15:0] exp_res [0:3];
        logic        exp_cmp [0:3];
        errs_at_start = error_count;
        // mul 2 x 3, min(1, -2), 1 < 2, abs(-5)
        op_a = '{16'h4000, 16'h3C00, 16'h3C00, 16'hC500};
        op_b = '{16'h4200, 16'hC000, 16'h4000, 16'h3C00};
        op_sel  = '{SEL_MUL, SEL_MIN, SEL_LT, SEL_ABS};
        exp_res = '{16'h4600, 16'hC000, 16'h0000, 16'h4500};
        exp_cmp = '{1'b0, 1'b0, 1'b1, 1'b0};
        drive_op(1'b0, op_a[0], op_b[0], op_sel[0]);
        for (int i = 1; i <= 4; i++) begin
            if (i < 4) begin
                drive_op(1'b0, op_a[i], op_b[i], op_sel[i]);
            end else begin
                @(posedge clk);
            end
            @(negedge clk);
            check_value("result", exp_res[i-1], result);
            check_value("cmp_out", widen_bit(exp_cmp[i-1]), widen_bit(cmp_out));
        end
        end_test("back_to_back", errs_at_start);
    endtask

    // ========================================
    // Sequence and watchdog
    // ========================================
    initial begin
        clk = 1'b0;
        rst_n     <= 1'b0;
        is_bf16   <= 1'b0;
        a         <= 16'h7D00;
        b         <= 16'hFE00;
        op_mul    <= 1'b0;
        op_min    <= 1'b0;
        op_max    <= 1'b0;
        op_abs    <= 1'b1;
        op_cmp_lt <= 1'b0;
        op_cmp_gt <= 1'b0;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        rng_state    = 32'd71232;
        build_pairs();
        reset_test();
        mul_test();
        compare_test();
        minmax_abs_test();
        back_to_back_test();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* fp16_alu.f */
verilog/fp16_alu_pkg.sv
verilog/fp_operand_if.sv
verilog/fp_operand_decode.sv
verilog/fp_mul_execute.sv
verilog/fp_compare_execute.sv
verilog/fp_result_stage.sv
verilog/fp16_alu.sv
sim/fp16_alu_checker.sv
sim/fp16_alu_tb.sv

/* Makefile */
BIN  = obj_dir/Vfp16_alu_tb
SRCS = $(wildcard verilog/*.sv sim/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): fp16_alu.f $(SRCS)
	verilator --binary --timing --assert --top-module fp16_alu_tb -f fp16_alu.f

run: $(BIN)
	$(BIN) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
